// File: list.f
rtl/soc_pkg.sv
rtl/dbg_fifo.sv
rtl/dbg_bus_master.sv
rtl/bus_decode.sv
rtl/misc_regs.sv
rtl/flash_reload_seq.sv
rtl/soc_ctrl_top.sv
verification/tb_soc_ctrl.sv

// File: run_sim.sh
#!/bin/bash
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_soc_ctrl -Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log 2>/dev/null && echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// File: verification/tb_soc_ctrl.sv
`timescale 1ns/100ps

module tb_soc_ctrl;

	localparam int clk_period_ns = 4;
	localparam int reset_cycles = 8;
	// expected length of each test in clock cycles
	localparam int led_test_cycles = 16;
	localparam int genio_test_cycles = 16;
	localparam int gpext_test_cycles = 24;
	localparam int berr_test_cycles = 12;
	localparam int fsel_test_cycles = 56;
	localparam int run_cycles = reset_cycles + led_test_cycles + genio_test_cycles
		+ gpext_test_cycles + berr_test_cycles + fsel_test_cycles;
	localparam int timeout_ns = 2 * run_cycles * clk_period_ns + 100;
	// all misc and sequencer outputs side by side
	localparam int state_w = 9 + 2 + 2 * soc_pkg::genio_w + 1 + 16 + 24 + 2;

	logic clk48m = 1'b0;
	logic rst;
	logic dbgreg_strobe;
	logic dbgreg_sel;
	soc_pkg::word_t dbgreg_in;
	logic bus_error;
	logic [8:0] led;
	logic trace_en;
	logic fsel_d;
	logic [soc_pkg::genio_w-1:0] genio_out;
	logic [soc_pkg::genio_w-1:0] genio_oe;
	logic irda_sd;
	logic [7:0] pmod_out;
	logic [7:0] pmod_oe;
	logic [5:0] sao1_out;
	logic [5:0] sao1_oe;
	logic [5:0] sao2_out;
	logic [5:0] sao2_oe;
	logic fsel_c;
	logic programn;

	int check_count = 0;
	int error_count = 0;
	soc_pkg::word_t berr_seen;
	soc_pkg::word_t fselc_seen;
	logic [state_w-1:0] misc_state;

	assign misc_state = {led, trace_en, fsel_d, genio_out, genio_oe, irda_sd, pmod_out,
		pmod_oe, sao1_out, sao1_oe, sao2_out, sao2_oe, fsel_c, programn};

	always #(clk_period_ns / 2) clk48m = ~clk48m;

	soc_ctrl_top DUT (
		.clk48m        (clk48m),
		.rst           (rst),
		.dbgreg_strobe (dbgreg_strobe),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_in     (dbgreg_in),
		.bus_error     (bus_error),
		.led           (led),
		.trace_en      (trace_en),
		.fsel_d        (fsel_d),
		.genio_out     (genio_out),
		.genio_oe      (genio_oe),
		.irda_sd       (irda_sd),
		.pmod_out      (pmod_out),
		.pmod_oe       (pmod_oe),
		.sao1_out      (sao1_out),
		.sao1_oe       (sao1_oe),
		.sao2_out      (sao2_out),
		.sao2_oe       (sao2_oe),
		.fsel_c        (fsel_c),
		.programn      (programn)
	);

	// count cycles with bus_error or fsel_c high at the falling edge
	always @(negedge clk48m) begin
		if (rst) begin
			berr_seen <= '0;
			fselc_seen <= '0;
		end else begin
			if (bus_error) begin
				berr_seen <= berr_seen + 32'd1;
			end
			if (fsel_c) begin
				fselc_seen <= fselc_seen + 32'd1;
			end
		end
	end

	task automatic check_word(input string name, input soc_pkg::word_t actual,
		input soc_pkg::word_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_genio(input string name, input logic [soc_pkg::genio_w-1:0] actual,
		input logic [soc_pkg::genio_w-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_state(input string name, input logic [state_w-1:0] actual,
		input logic [state_w-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one strobe cycle, then one idle cycle so the master can pop
	task automatic dbg_push(input logic sel, input soc_pkg::word_t word);
		@(posedge clk48m);
		#1;
		dbgreg_strobe = 1'b1;
		dbgreg_sel = sel;
		dbgreg_in = word;
		@(posedge clk48m);
		#1;
		dbgreg_strobe = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk48m);
		#1;
	endtask

	// programn sampled every cycle for n cycles
	task automatic watch_programn(input int n, input logic expected);
		repeat (n) begin
			@(negedge clk48m);
			check_bit("programn", programn, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_led_trace();
		int errors_before;
		soc_pkg::word_t led_val;
		errors_before = error_count;
		led_val = $urandom();
		check_bit("trace_en", trace_en, 1'b0);
		dbg_push(1'b1, 32'h2000_0000);
		dbg_push(1'b0, led_val);
		dbg_push(1'b1, 32'h2000_0008);
		dbg_push(1'b0, 32'h0000_0001);
		idle_cycles(4);
		check_word("led", 32'(led), 32'(led_val[8:0]));
		check_bit("trace_en", trace_en, 1'b1);
		report_test("led_trace", errors_before);
	endtask

	task automatic test_genio();
		int errors_before;
		soc_pkg::word_t out_val;
		soc_pkg::word_t oe_val;
		soc_pkg::word_t set_mask;
		soc_pkg::word_t clr_mask;
		soc_pkg::word_t expected;
		errors_before = error_count;
		out_val = $urandom();
		oe_val = $urandom();
		set_mask = $urandom();
		clr_mask = $urandom();
		// out, oe, set and clear sit at consecutive word addresses
		dbg_push(1'b1, 32'h2000_003C);
		dbg_push(1'b0, out_val);
		dbg_push(1'b0, oe_val);
		dbg_push(1'b0, set_mask);
		dbg_push(1'b0, clr_mask);
		idle_cycles(4);
		expected = (out_val | set_mask) & ~clr_mask;
		check_genio("genio_out", genio_out, expected[soc_pkg::genio_w-1:0]);
		check_genio("genio_oe", genio_oe, oe_val[soc_pkg::genio_w-1:0]);
		report_test("genio", errors_before);
	endtask

	task automatic test_gpext();
		int errors_before;
		soc_pkg::word_t out_val;
		soc_pkg::word_t oe_val;
		soc_pkg::word_t set_mask;
		soc_pkg::word_t clr_mask;
		soc_pkg::word_t expected;
		errors_before = error_count;
		out_val = $urandom();
		oe_val = $urandom();
		set_mask = $urandom();
		clr_mask = $urandom();
		// irda_sd is cleared by the plain write and set again by the alias
		out_val[30] = 1'b0;
		set_mask[30] = 1'b1;
		clr_mask[30] = 1'b0;
		check_bit("irda_sd", irda_sd, 1'b1);
		dbg_push(1'b1, 32'h2000_0050);
		dbg_push(1'b0, out_val);
		idle_cycles(4);
		check_bit("irda_sd", irda_sd, 1'b0);
		dbg_push(1'b0, oe_val);
		dbg_push(1'b0, set_mask);
		dbg_push(1'b0, clr_mask);
		idle_cycles(4);
		expected = (out_val | set_mask) & ~clr_mask;
		check_bit("irda_sd", irda_sd, expected[30]);
		check_word("pmod_out", 32'(pmod_out), 32'(expected[23:16]));
		check_word("sao2_out", 32'(sao2_out), 32'(expected[13:8]));
		check_word("sao1_out", 32'(sao1_out), 32'(expected[5:0]));
		check_word("pmod_oe", 32'(pmod_oe), 32'(oe_val[23:16]));
		check_word("sao2_oe", 32'(sao2_oe), 32'(oe_val[13:8]));
		check_word("sao1_oe", 32'(sao1_oe), 32'(oe_val[5:0]));
		report_test("gpext", errors_before);
	endtask

	task automatic test_bus_error();
		int errors_before;
		soc_pkg::word_t berr_start;
		logic [state_w-1:0] state_before;
		errors_before = error_count;
		berr_start = berr_seen;
		state_before = misc_state;
		dbg_push(1'b1, 32'h5000_0000);
		dbg_push(1'b0, 32'h0000_01FF);
		idle_cycles(4);
		check_word("bus_error cycles", berr_seen - berr_start, 32'd1);
		check_state("misc outputs", misc_state, state_before);
		report_test("bus_error", errors_before);
	endtask

	task automatic test_flash_select();
		int errors_before;
		soc_pkg::word_t fselc_start;
		errors_before = error_count;
		check_bit("programn", programn, 1'b1);
		check_bit("fsel_c", fsel_c, 1'b0);
		// plain select write without the key
		fselc_start = fselc_seen;
		dbg_push(1'b1, 32'h2000_002C);
		dbg_push(1'b0, 32'h0000_0001);
		watch_programn(14, 1'b1);
		check_bit("fsel_d", fsel_d, 1'b1);
		check_word("fsel_c cycles", fselc_seen - fselc_start, 32'd3);
		// keyed write drops programn for good
		fselc_start = fselc_seen;
		dbg_push(1'b1, 32'h2000_002C);
		dbg_push(1'b0, 32'hD0F1_A501);
		idle_cycles(14);
		check_bit("fsel_d", fsel_d, 1'b1);
		check_word("fsel_c cycles", fselc_seen - fselc_start, 32'd3);
		watch_programn(8, 1'b0);
		report_test("flash_select", errors_before);
	endtask

	initial begin
		#(timeout_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", timeout_ns);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h860b_4d6a));
		rst = 1'b1;
		dbgreg_strobe = 1'b0;
		dbgreg_sel = 1'b0;
		dbgreg_in = '0;
		repeat (reset_cycles) @(posedge clk48m);
		#1;
		rst = 1'b0;
		test_led_trace();
		test_genio();
		test_gpext();
		test_bus_error();
		test_flash_select();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/soc_ctrl_top.sv
`timescale 1ns/100ps

module soc_ctrl_top (
	input  logic                         clk48m,
	input  logic                         rst,
	input  logic                         dbgreg_strobe,
	input  logic                         dbgreg_sel,
	input  soc_pkg::word_t               dbgreg_in,
	output logic                         bus_error,
	output logic [8:0]                   led,
	output logic                         trace_en,
	output logic                         fsel_d,
	output logic [soc_pkg::genio_w-1:0]  genio_out,
	output logic [soc_pkg::genio_w-1:0]  genio_oe,
	output logic                         irda_sd,
	output logic [7:0]                   pmod_out,
	output logic [7:0]                   pmod_oe,
	output logic [5:0]                   sao1_out,
	output logic [5:0]                   sao1_oe,
	output logic [5:0]                   sao2_out,
	output logic [5:0]                   sao2_oe,
	output logic                         fsel_c,
	output logic                         programn
);

	// debug queue to bus master
	soc_pkg::dbg_entry_t fifo_entry;
	logic                fifo_empty;
	logic                fifo_pop;

	// debug bus
	logic                bus_valid;
	soc_pkg::word_t      bus_addr;
	soc_pkg::word_t      bus_wdata;
	logic                bus_ready;

	// misc block strobes
	logic                misc_wr;
	logic                fsel_wr;
	logic                reload_req;

	dbg_fifo u_dbg_fifo (
		.clk48m     (clk48m),
		.rst        (rst),
		.push       (dbgreg_strobe),
		.push_entry ({dbgreg_sel, dbgreg_in}),
		.pop        (fifo_pop),
		.entry      (fifo_entry),
		.empty      (fifo_empty)
	);

	dbg_bus_master u_dbg_bus_master (
		.clk48m    (clk48m),
		.rst       (rst),
		.strobe    (dbgreg_strobe),
		.entry     (fifo_entry),
		.empty     (fifo_empty),
		.pop       (fifo_pop),
		.bus_valid (bus_valid),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ready (bus_ready)
	);

	bus_decode u_bus_decode (
		.bus_valid (bus_valid),
		.bus_addr  (bus_addr),
		.bus_ready (bus_ready),
		.misc_wr   (misc_wr),
		.bus_error (bus_error)
	);

	misc_regs u_misc_regs (
		.clk48m     (clk48m),
		.rst        (rst),
		.misc_wr    (misc_wr),
		.reg_index  (bus_addr[6:2]),
		.wdata      (bus_wdata),
		.led        (led),
		.trace_en   (trace_en),
		.fsel_d     (fsel_d),
		.genio_out  (genio_out),
		.genio_oe   (genio_oe),
		.irda_sd    (irda_sd),
		.pmod_out   (pmod_out),
		.pmod_oe    (pmod_oe),
		.sao1_out   (sao1_out),
		.sao1_oe    (sao1_oe),
		.sao2_out   (sao2_out),
		.sao2_oe    (sao2_oe),
		.fsel_wr    (fsel_wr),
		.reload_req (reload_req)
	);

	flash_reload_seq u_flash_reload_seq (
		.clk48m     (clk48m),
		.rst        (rst),
		.fsel_wr    (fsel_wr),
		.reload_req (reload_req),
		.fsel_c     (fsel_c),
		.programn   (programn)
	);

endmodule

// File: rtl/flash_reload_seq.sv
`timescale 1ns/100ps

module flash_reload_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_wr,
	input  logic reload_req,
	output logic fsel_c,
	output logic programn
);

	logic [2:0] fsel_delay;
	logic       reload_pend;
	logic       reload;

	// clock the select flop in the middle of the countdown so fsel_d
	// has settled before and programn comes well after
	assign fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);
	assign programn = ~reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			reload_pend <= 1'b0;
			reload <= 1'b0;
		end else begin
			// once keyed, the reload stays armed
			if (reload_req) begin
				reload_pend <= 1'b1;
			end
			if (fsel_wr) begin
				fsel_delay <= soc_pkg::fsel_delay_load;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
				// pull programn at the end of the countdown and never release it
				if (fsel_delay == 3'd1 && reload_pend) begin
					reload <= 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/misc_regs.sv
`timescale 1ns/100ps

module misc_regs (
	input  logic                         clk48m,
	input  logic                         rst,
	input  logic                         misc_wr,
	input  soc_pkg::reg_index_t          reg_index,
	input  soc_pkg::word_t               wdata,
	output logic [8:0]                   led,
	output logic                         trace_en,
	output logic                         fsel_d,
	output logic [soc_pkg::genio_w-1:0]  genio_out,
	output logic [soc_pkg::genio_w-1:0]  genio_oe,
	output logic                         irda_sd,
	output logic [7:0]                   pmod_out,
	output logic [7:0]                   pmod_oe,
	output logic [5:0]                   sao1_out,
	output logic [5:0]                   sao1_oe,
	output logic [5:0]                   sao2_out,
	output logic [5:0]                   sao2_oe,
	output logic                         fsel_wr,
	output logic                         reload_req
);

	logic [soc_pkg::led_w-1:0] led_reg;

	// only the low 9 bits reach the pins
	assign led = led_reg[8:0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_reg <= '0;
			trace_en <= 1'b0;
			fsel_d <= 1'b0;
			genio_out <= '0;
			genio_oe <= '0;
			irda_sd <= soc_pkg::irda_sd_reset;
			pmod_out <= '0;
			pmod_oe <= '0;
			sao1_out <= '0;
			sao1_oe <= '0;
			sao2_out <= '0;
			sao2_oe <= '0;
			fsel_wr <= 1'b0;
			reload_req <= 1'b0;
		end else begin
			fsel_wr <= 1'b0;
			reload_req <= 1'b0;
			if (misc_wr) begin
				case (reg_index)
					soc_pkg::reg_led: begin
						led_reg <= wdata[soc_pkg::led_w-1:0];
					end
					// the version register is read only and its write slot toggles tracing
					soc_pkg::reg_soc_ver: begin
						trace_en <= wdata[0];
					end
					soc_pkg::reg_flash_sel: begin
						fsel_d <= wdata[0];
						fsel_wr <= 1'b1;
						if (wdata[31:8] == soc_pkg::reload_key) begin
							reload_req <= 1'b1;
						end
					end
					soc_pkg::reg_genio_out: begin
						genio_out <= wdata[soc_pkg::genio_w-1:0];
					end
					soc_pkg::reg_genio_oe: begin
						genio_oe <= wdata[soc_pkg::genio_w-1:0];
					end
					soc_pkg::reg_genio_w2s: begin
						genio_out <= genio_out | wdata[soc_pkg::genio_w-1:0];
					end
					soc_pkg::reg_genio_w2c: begin
						genio_out <= genio_out & ~wdata[soc_pkg::genio_w-1:0];
					end
					// irda_sd sits at bit 30, pmod at 23..16, sao2 at 13..8 and sao1 at 5..0
					soc_pkg::reg_gpext_out: begin
						irda_sd <= wdata[30];
						pmod_out <= wdata[23:16];
						sao2_out <= wdata[13:8];
						sao1_out <= wdata[5:0];
					end
					soc_pkg::reg_gpext_oe: begin
						pmod_oe <= wdata[23:16];
						sao2_oe <= wdata[13:8];
						sao1_oe <= wdata[5:0];
					end
					soc_pkg::reg_gpext_w2s: begin
						irda_sd <= irda_sd | wdata[30];
						pmod_out <= pmod_out | wdata[23:16];
						sao2_out <= sao2_out | wdata[13:8];
						sao1_out <= sao1_out | wdata[5:0];
					end
					soc_pkg::reg_gpext_w2c: begin
						irda_sd <= irda_sd & ~wdata[30];
						pmod_out <= pmod_out & ~wdata[23:16];
						sao2_out <= sao2_out & ~wdata[13:8];
						sao1_out <= sao1_out & ~wdata[5:0];
					end
					default: begin
						// writes to unused indices are dropped
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/bus_decode.sv
`timescale 1ns/100ps

module bus_decode (
	input  logic              bus_valid,
	input  soc_pkg::word_t    bus_addr,
	output logic              bus_ready,
	output logic              misc_wr,
	output logic              bus_error
);

	logic misc_hit;

	// only the misc block is left on the bus
	assign misc_hit = (bus_addr[31:28] == soc_pkg::region_misc);

	always_comb begin
		misc_wr = 1'b0;
		bus_error = 1'b0;
		if (misc_hit) begin
			misc_wr = bus_valid;
		end else begin
			// unmapped region
			bus_error = bus_valid;
		end
	end

	// misc regs and errors both complete immediately
	assign bus_ready = bus_valid;

endmodule

// File: rtl/dbg_bus_master.sv
`timescale 1ns/100ps

module dbg_bus_master (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   strobe,
	input  soc_pkg::dbg_entry_t    entry,
	input  logic                   empty,
	output logic                   pop,
	output logic                   bus_valid,
	output soc_pkg::word_t         bus_addr,
	output soc_pkg::word_t         bus_wdata,
	input  logic                   bus_ready
);

	// a strobe owns the queue this cycle, so popping waits
	// one write in flight at a time
	assign pop = !strobe && !bus_valid && !empty;

	// valid and address
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_valid <= 1'b0;
			bus_addr <= '0;
		end else begin
			if (bus_valid) begin
				// transfer completes in the cycle ready is seen
				if (bus_ready) begin
					bus_valid <= 1'b0;
					bus_addr <= bus_addr + 32'd4;
				end
			end else if (pop) begin
				if (entry.sel) begin
					bus_addr <= entry.word;
				end else begin
					bus_valid <= 1'b1;
				end
			end
		end
	end

	// write data only changes when a data entry is popped
	always_ff @(posedge clk48m) begin
		if (pop && !entry.sel) begin
			bus_wdata <= entry.word;
		end
	end

endmodule

// File: rtl/dbg_fifo.sv
`timescale 1ns/100ps

module dbg_fifo (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   push,
	input  soc_pkg::dbg_entry_t    push_entry,
	input  logic                   pop,
	output soc_pkg::dbg_entry_t    entry,
	output logic                   empty
);

	// entry storage
	soc_pkg::dbg_entry_t mem [soc_pkg::dbg_fifo_depth];

	logic [soc_pkg::dbg_ptr_w-1:0] wptr;
	logic [soc_pkg::dbg_ptr_w-1:0] rptr;

	// write side
	always_ff @(posedge clk48m) begin
		if (push) begin
			mem[wptr] <= push_entry;
		end
	end

	// pointers wrap naturally at the queue depth
	// a burst of more than 32 unread entries overwrites old ones
	always_ff @(posedge clk48m) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// head of queue is visible without a read cycle
	assign entry = mem[rptr];
	assign empty = (wptr == rptr);

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

	// bus words
	typedef logic [31:0] word_t;

	// debug queue entry where sel=1 carries an address and sel=0 carries data
	typedef struct packed {
		logic  sel;
		word_t word;
	} dbg_entry_t;

	// debug queue geometry
	localparam int unsigned dbg_fifo_depth = 32;
	localparam int unsigned dbg_ptr_w = 5;

	// region code in the top nibble of the bus address
	localparam logic [3:0] region_misc = 4'h2;

	// misc register index from address bits 6..2
	typedef logic [4:0] reg_index_t;

	localparam reg_index_t reg_led       = 5'd0;
	localparam reg_index_t reg_soc_ver   = 5'd2;
	localparam reg_index_t reg_flash_sel = 5'd11;
	localparam reg_index_t reg_genio_out = 5'd15;
	localparam reg_index_t reg_genio_oe  = 5'd16;
	localparam reg_index_t reg_genio_w2s = 5'd17;
	localparam reg_index_t reg_genio_w2c = 5'd18;
	localparam reg_index_t reg_gpext_out = 5'd20;
	localparam reg_index_t reg_gpext_oe  = 5'd21;
	localparam reg_index_t reg_gpext_w2s = 5'd22;
	localparam reg_index_t reg_gpext_w2c = 5'd23;

	// register widths
	localparam int unsigned genio_w = 30;
	localparam int unsigned led_w = 16;

	// flash select write with this key in bits 31..8 reloads the FPGA
	localparam logic [23:0] reload_key = 24'hD0F1A5;

	// start value of the fsel clock delay counter
	localparam logic [2:0] fsel_delay_load = 3'd7;

	// irda transceiver starts in shutdown
	localparam logic irda_sd_reset = 1'b1;

endpackage
